/* source/blit_pkg.sv */
// Blitter inner loop definitions
`default_nettype none

package blit_pkg;

	// Host data word and pixel count widths
	localparam int word_w = 32;
	localparam int count_w = 16;

	// Pixel count as loaded from the host
	typedef logic [count_w-1:0] count_t;

	// One-hot cycle state, one bit per memory cycle plus idle
	localparam int num_states = 9;
	typedef logic [num_states-1:0] state_t;

	// Bit positions in state_t, listed in cycle order
	// The six read states sit next to each other
	localparam int st_idle = 0;
	localparam int st_sreadx = 1;
	localparam int st_szreadx = 2;
	localparam int st_sread = 3;
	localparam int st_szread = 4;
	localparam int st_dread = 5;
	localparam int st_dzread = 6;
	localparam int st_dwrite = 7;
	localparam int st_dzwrite = 8;

	// Command enables, src_en lands on host bit 0
	typedef struct packed {
		logic reserved;
		logic dstwrz_en;
		logic dstz_en;
		logic dst_en;
		logic srcx_en;
		logic srcz_en;
		logic src_en;
	} cmd_flags_t;

	// Host word seen as a command
	typedef struct packed {
		logic [word_w-$bits(cmd_flags_t)-1:0] pad;
		cmd_flags_t flags;
	} cmd_word_t;

	// Host word seen as a pixel count
	typedef struct packed {
		logic [word_w-count_w-1:0] pad;
		count_t count;
	} cnt_word_t;

	// Same host bus, decoded by whichever load strobe fires
	typedef union packed {
		cmd_word_t cmd;
		cnt_word_t cnt;
	} blit_word_t;

endpackage

`default_nettype wire

/* source/blit_inner_seq.sv */
// Blitter inner loop cycle sequencer
`default_nettype none

module blit_inner_seq (
	input wire sys_clk,
	input wire resetl,
	input wire blit_pkg::blit_word_t host_data,
	input wire cmd_load,
	input wire inner_start,
	input wire mem_ready,
	input wire no_write,
	input wire reads_clear,
	input wire last_pixel,
	output blit_pkg::state_t cur_state,
	output logic read_req,
	output logic write_req,
	output logic z_cycle,
	output logic dst_cycle,
	output logic inner_busy,
	output logic pixel_step
);

	// Latched command enables
	blit_pkg::cmd_flags_t flags;
	// Start seen but not yet taken by idle
	logic start_pend;
	logic step;
	logic is_idle;
	logic in_read;
	logic in_write;
	// Current state is the last write of the pixel
	logic final_write;
	// Entry points into the cycle order
	blit_pkg::state_t d_entry;
	blit_pkg::state_t s_entry;
	blit_pkg::state_t x_entry;
	// Where a finished pixel goes
	blit_pkg::state_t pix_next;
	blit_pkg::state_t next_state;

	// One-hot vector with a single state bit set
	function automatic blit_pkg::state_t one_state(input int idx);
		blit_pkg::state_t s;
		s = '0;
		s[idx] = 1'b1;
		return s;
	endfunction

	// Command enables from the host word
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			flags <= '0;
		end else if (cmd_load) begin
			flags <= host_data.cmd.flags;
		end
	end

	// Hold a start until idle steps on it
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			start_pend <= 1'b0;
		end else begin
			start_pend <= (start_pend | inner_start) & ~(is_idle & step);
		end
	end

	assign is_idle = cur_state[blit_pkg::st_idle];

	// Idle steps on start, the rest on memory ready
	// Destination write also waits for every read of the pixel
	always_comb begin
		if (is_idle) begin
			step = (start_pend | inner_start) & mem_ready;
		end else begin
			step = mem_ready & (~cur_state[blit_pkg::st_dwrite] | reads_clear);
		end
	end

	// First enabled state of the destination, source and extra groups
	always_comb begin
		if (flags.dst_en) begin
			d_entry = one_state(blit_pkg::st_dread);
		end else if (flags.dstz_en) begin
			d_entry = one_state(blit_pkg::st_dzread);
		end else begin
			d_entry = one_state(blit_pkg::st_dwrite);
		end
		s_entry = flags.src_en ? one_state(blit_pkg::st_sread) : d_entry;
		x_entry = flags.srcx_en ? one_state(blit_pkg::st_sreadx) : s_entry;
		// Next pixel restarts at the source read
		pix_next = last_pixel ? one_state(blit_pkg::st_idle) : s_entry;
	end

	// Walk the enabled cycles, skipping disabled ones
	always_comb begin
		case (1'b1)
			cur_state[blit_pkg::st_idle]: begin
				next_state = x_entry;
			end
			cur_state[blit_pkg::st_sreadx]: begin
				next_state = flags.srcz_en ? one_state(blit_pkg::st_szreadx) : s_entry;
			end
			cur_state[blit_pkg::st_szreadx]: begin
				next_state = s_entry;
			end
			cur_state[blit_pkg::st_sread]: begin
				next_state = flags.srcz_en ? one_state(blit_pkg::st_szread) : d_entry;
			end
			cur_state[blit_pkg::st_szread]: begin
				next_state = d_entry;
			end
			cur_state[blit_pkg::st_dread]: begin
				if (flags.dstz_en) begin
					next_state = one_state(blit_pkg::st_dzread);
				end else begin
					next_state = one_state(blit_pkg::st_dwrite);
				end
			end
			cur_state[blit_pkg::st_dzread]: begin
				next_state = one_state(blit_pkg::st_dwrite);
			end
			cur_state[blit_pkg::st_dwrite]: begin
				next_state = flags.dstwrz_en ? one_state(blit_pkg::st_dzwrite) : pix_next;
			end
			cur_state[blit_pkg::st_dzwrite]: begin
				next_state = pix_next;
			end
			default: begin
				next_state = one_state(blit_pkg::st_idle);
			end
		endcase
	end

	// One state change per step
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cur_state <= one_state(blit_pkg::st_idle);
		end else if (step) begin
			cur_state <= next_state;
		end
	end

	// State decodes
	assign in_read = |cur_state[blit_pkg::st_dzread:blit_pkg::st_sreadx];
	assign in_write = cur_state[blit_pkg::st_dwrite] | cur_state[blit_pkg::st_dzwrite];
	assign final_write = cur_state[blit_pkg::st_dzwrite]
		| (cur_state[blit_pkg::st_dwrite] & ~flags.dstwrz_en);

	// Requests only in step cycles
	assign read_req = step & in_read;
	assign write_req = step & in_write & ~no_write;

	// Z and destination markings follow the state alone
	assign z_cycle = cur_state[blit_pkg::st_szreadx] | cur_state[blit_pkg::st_szread]
		| cur_state[blit_pkg::st_dzread] | cur_state[blit_pkg::st_dzwrite];
	assign dst_cycle = cur_state[blit_pkg::st_dread] | cur_state[blit_pkg::st_dzread]
		| in_write;
	assign inner_busy = ~is_idle;

	// Pixel ends on the step out of its last write
	assign pixel_step = step & final_write;

	// Exactly one state active at a time
	a_state_onehot: assert property (@(posedge sys_clk) disable iff (!resetl)
		$onehot(cur_state));

	// Never a read and a write request in one cycle
	a_req_exclusive: assert property (@(posedge sys_clk) disable iff (!resetl)
		!(read_req && write_req));

endmodule

`default_nettype wire

/* source/blit_read_track.sv */
// Blitter read tracker
`default_nettype none

module blit_read_track (
	input wire sys_clk,
	input wire resetl,
	input wire blit_pkg::state_t cur_state,
	input wire read_req,
	input wire read_ack,
	output logic reads_clear,
	output logic src_data_rd,
	output logic src_z_rd,
	output logic dst_data_rd,
	output logic dst_z_rd
);

	// One pending flag per read state, indexed like the state vector
	// Lower index means issued earlier in the pixel
	logic [blit_pkg::st_dzread:blit_pkg::st_sreadx] pend;
	// Flag set by this cycle's request
	logic [blit_pkg::st_dzread:blit_pkg::st_sreadx] rd_set;
	// Flag served by this cycle's acknowledge
	logic [blit_pkg::st_dzread:blit_pkg::st_sreadx] ack_hit;
	// Oldest pending already found
	logic found;

	// Request tags the state it was issued from
	assign rd_set = {($bits(rd_set)){read_req}}
		& cur_state[blit_pkg::st_dzread:blit_pkg::st_sreadx];

	// Steer the acknowledge to the oldest pending read
	always_comb begin
		found = 1'b0;
		ack_hit = '0;
		for (int i = blit_pkg::st_sreadx; i <= blit_pkg::st_dzread; i++) begin
			if (read_ack && pend[i] && !found) begin
				ack_hit[i] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// Set after the request, clear after the acknowledge
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pend <= '0;
		end else begin
			pend <= (pend & ~ack_hit) | rd_set;
		end
	end

	// Clear once the last pending read is acknowledged this cycle
	// so the destination write can step without a dead cycle
	assign reads_clear = ~|(pend & ~ack_hit) & ~read_req;

	// Extra and normal source reads share a strobe
	assign src_data_rd = ack_hit[blit_pkg::st_sreadx] | ack_hit[blit_pkg::st_sread];
	assign src_z_rd = ack_hit[blit_pkg::st_szreadx] | ack_hit[blit_pkg::st_szread];
	assign dst_data_rd = ack_hit[blit_pkg::st_dread];
	assign dst_z_rd = ack_hit[blit_pkg::st_dzread];

	// Memory returns nothing it was not asked for
	a_ack_has_pending: assert property (@(posedge sys_clk) disable iff (!resetl)
		read_ack |-> |pend);

	// A read state is never reissued before its data is back
	a_no_double_set: assert property (@(posedge sys_clk) disable iff (!resetl)
		!(|(rd_set & pend)));

endmodule

`default_nettype wire

/* source/blit_pixel_count.sv */
// Blitter inner loop pixel counter
`default_nettype none

module blit_pixel_count (
	input wire sys_clk,
	input wire resetl,
	input wire blit_pkg::blit_word_t host_data,
	input wire count_load,
	input wire pixel_step,
	output blit_pkg::count_t pixels_left,
	output logic last_pixel,
	output logic inner_done
);

	// Host load wins over a step in the same cycle
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pixels_left <= '0;
		end else if (count_load) begin
			pixels_left <= host_data.cnt.count;
		end else if (pixel_step) begin
			pixels_left <= pixels_left - blit_pkg::count_t'(1);
		end
	end

	// Pixel in flight is the final one
	assign last_pixel = (pixels_left == blit_pkg::count_t'(1));

	// Done one cycle after the last pixel's final write
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			inner_done <= 1'b0;
		end else begin
			inner_done <= pixel_step & last_pixel;
		end
	end

	// Sequencer stops at idle before the count can wrap
	a_no_step_at_zero: assert property (@(posedge sys_clk) disable iff (!resetl)
		pixel_step |-> (pixels_left != '0));

endmodule

`default_nettype wire

/* source/blit_inner_top.sv */
// Blitter inner loop top level
`default_nettype none

module blit_inner_top (
	input wire sys_clk,
	input wire resetl,
	input wire [blit_pkg::word_w-1:0] host_data,
	input wire cmd_load,
	input wire count_load,
	input wire inner_start,
	input wire mem_ready,
	input wire read_ack,
	input wire no_write,
	output logic read_req,
	output logic write_req,
	output logic z_cycle,
	output logic dst_cycle,
	output logic inner_busy,
	output logic inner_done,
	output logic src_data_rd,
	output logic src_z_rd,
	output logic dst_data_rd,
	output logic dst_z_rd,
	output blit_pkg::count_t pixels_left
);

	// State being left on a step, for read tagging
	blit_pkg::state_t cur_state;
	// No read outstanding and none going out
	logic reads_clear;
	// Pixel finished, and count at one
	logic pixel_step;
	logic last_pixel;

	// Cycle sequencer and request generation
	blit_inner_seq u_seq (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.host_data(host_data),
		.cmd_load(cmd_load),
		.inner_start(inner_start),
		.mem_ready(mem_ready),
		.no_write(no_write),
		.reads_clear(reads_clear),
		.last_pixel(last_pixel),
		.cur_state(cur_state),
		.read_req(read_req),
		.write_req(write_req),
		.z_cycle(z_cycle),
		.dst_cycle(dst_cycle),
		.inner_busy(inner_busy),
		.pixel_step(pixel_step)
	);

	// Outstanding reads and data strobes
	blit_read_track u_track (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.cur_state(cur_state),
		.read_req(read_req),
		.read_ack(read_ack),
		.reads_clear(reads_clear),
		.src_data_rd(src_data_rd),
		.src_z_rd(src_z_rd),
		.dst_data_rd(dst_data_rd),
		.dst_z_rd(dst_z_rd)
	);

	// Pixels remaining and done pulse
	blit_pixel_count u_count (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.host_data(host_data),
		.count_load(count_load),
		.pixel_step(pixel_step),
		.pixels_left(pixels_left),
		.last_pixel(last_pixel),
		.inner_done(inner_done)
	);

endmodule

`default_nettype wire

/* dv/tb_blit_inner_tests.svh */
// Blitter inner loop directed tests
`ifndef TB_BLIT_INNER_TESTS_SVH
`define TB_BLIT_INNER_TESTS_SVH

	// Outputs straight out of reset
	task automatic check_reset_state();
		#2;
		check_bit("inner_busy", inner_busy, 1'b0);
		check_bit("inner_done", inner_done, 1'b0);
		check_bit("read_req", read_req, 1'b0);
		check_bit("write_req", write_req, 1'b0);
		check_bit("src_data_rd", src_data_rd, 1'b0);
		check_bit("src_z_rd", src_z_rd, 1'b0);
		check_bit("dst_data_rd", dst_data_rd, 1'b0);
		check_bit("dst_z_rd", dst_z_rd, 1'b0);
		check_count("pixels_left", pixels_left, 16'd0);
	endtask

	// Command word through the flag view of the host bus
	task automatic load_cmd(input blit_pkg::cmd_flags_t f);
		blit_pkg::blit_word_t w;
		w = '0;
		w.cmd.flags = f;
		@(negedge sys_clk);
		host_data = w;
		cmd_load = 1'b1;
		@(negedge sys_clk);
		cmd_load = 1'b0;
	endtask

	// Count word through the count view and read back after the edge
	task automatic load_count(input blit_pkg::count_t n);
		blit_pkg::blit_word_t w;
		w = '0;
		w.cnt.count = n;
		@(negedge sys_clk);
		host_data = w;
		count_load = 1'b1;
		@(negedge sys_clk);
		count_load = 1'b0;
		#2;
		check_count("pixels_left", pixels_left, n);
	endtask

	// All cycles enabled, three pixels, prompt data
	task automatic test_full_sequence();
		load_cmd(7'h3f);
		load_count(16'd3);
		run_blit(7'h3f, 16'd3, 1'b0, 1'b0, 1'b0);
	endtask

	// Every flag pattern with the reserved bit, one pixel each
	task automatic test_all_flag_combos();
		blit_pkg::cmd_flags_t f;
		for (int i = 0; i < 128; i++) begin
			f = blit_pkg::cmd_flags_t'(i[6:0]);
			load_cmd(f);
			load_count(16'd1);
			run_blit(f, 16'd1, 1'b0, 1'b0, 1'b0);
		end
	endtask

	// Slow memory data must hold back the destination write
	task automatic test_ack_delays();
		load_cmd(7'h3f);
		load_count(16'd4);
		run_blit(7'h3f, 16'd4, 1'b1, 1'b0, 1'b0);
		load_cmd(7'h1b);
		load_count(16'd3);
		run_blit(7'h1b, 16'd3, 1'b1, 1'b0, 1'b0);
	endtask

	// Ready gaps stall the walk without changing it
	task automatic test_ready_gaps();
		load_cmd(7'h3f);
		load_count(16'd3);
		run_blit(7'h3f, 16'd3, 1'b0, 1'b1, 1'b0);
		load_cmd(7'h2d);
		load_count(16'd4);
		run_blit(7'h2d, 16'd4, 1'b1, 1'b1, 1'b0);
	endtask

	// Writes suppressed while states and done still run
	task automatic test_no_write();
		load_cmd(7'h3f);
		load_count(16'd2);
		run_blit(7'h3f, 16'd2, 1'b0, 1'b0, 1'b1);
		check_count("pixels_left", pixels_left, 16'd0);
		no_write = 1'b0;
	endtask

	// Count loads, steps down once per pixel and ends at zero
	task automatic test_pixel_count();
		load_cmd(7'h09);
		load_count(16'd5);
		run_blit(7'h09, 16'd5, 1'b1, 1'b1, 1'b0);
		check_count("pixels_left", pixels_left, 16'd0);
	endtask

`endif

/* dv/tb_blit_inner.sv */
// Blitter inner loop testbench
`default_nettype none

module tb_blit_inner;

	// Cycle budget of all runs summed, times a margin of four
	localparam int test_cycles = 128 * 20 + 10 * 200;
	localparam int watchdog_time = (test_cycles + 20) * 10 * 4;

	logic sys_clk;
	logic resetl;
	logic [blit_pkg::word_w-1:0] host_data;
	logic cmd_load;
	logic count_load;
	logic inner_start;
	logic mem_ready;
	logic read_ack;
	logic no_write;
	logic read_req;
	logic write_req;
	logic z_cycle;
	logic dst_cycle;
	logic inner_busy;
	logic inner_done;
	logic src_data_rd;
	logic src_z_rd;
	logic dst_data_rd;
	logic dst_z_rd;
	blit_pkg::count_t pixels_left;

	int errors = 0;
	int seed = 16049;
	// Step records as {read_req, write_req, z_cycle, dst_cycle}
	logic [3:0] exp_seq[$];
	logic [3:0] obs_seq[$];
	// Reads not yet acknowledged as {z_cycle, dst_cycle}
	logic [1:0] pend_q[$];

	blit_inner_top u_dut (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.host_data(host_data),
		.cmd_load(cmd_load),
		.count_load(count_load),
		.inner_start(inner_start),
		.mem_ready(mem_ready),
		.read_ack(read_ack),
		.no_write(no_write),
		.read_req(read_req),
		.write_req(write_req),
		.z_cycle(z_cycle),
		.dst_cycle(dst_cycle),
		.inner_busy(inner_busy),
		.inner_done(inner_done),
		.src_data_rd(src_data_rd),
		.src_z_rd(src_z_rd),
		.dst_data_rd(dst_data_rd),
		.dst_z_rd(dst_z_rd),
		.pixels_left(pixels_left)
	);

	always #5 sys_clk = ~sys_clk;

	// Single-bit result against its expected value
	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s at %0t: got 'h%h expected 'h%h", name, $time, got, exp);
		end
	endtask

	// Pixel count result against its expected value
	task automatic check_count(input string name, input blit_pkg::count_t got,
			input blit_pkg::count_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s at %0t: got 'h%h expected 'h%h", name, $time, got, exp);
		end
	endtask

	// Reference cycle order for a whole blit
	task automatic expected_cycles(input blit_pkg::cmd_flags_t f, input blit_pkg::count_t cnt,
			input logic nw);
		exp_seq.delete();
		for (int p = 0; p < int'(cnt); p++) begin
			// Extra source reads only lead the first pixel
			if (p == 0 && f.srcx_en) begin
				exp_seq.push_back(4'b1000);
				if (f.srcz_en)
					exp_seq.push_back(4'b1010);
			end
			if (f.src_en) begin
				exp_seq.push_back(4'b1000);
				if (f.srcz_en)
					exp_seq.push_back(4'b1010);
			end
			if (f.dst_en)
				exp_seq.push_back(4'b1001);
			if (f.dstz_en)
				exp_seq.push_back(4'b1011);
			// Writes vanish from the request list under no_write
			if (!nw) begin
				exp_seq.push_back(4'b0101);
				if (f.dstwrz_en)
					exp_seq.push_back(4'b0111);
			end
		end
	endtask

	// Strobe pattern {src_data, src_z, dst_data, dst_z} for a read kind {z, dst}
	function automatic logic [3:0] strobe_for(input logic [1:0] kind);
		case (kind)
			2'b00: return 4'b1000;
			2'b10: return 4'b0100;
			2'b01: return 4'b0010;
			default: return 4'b0001;
		endcase
	endfunction

	// Observed steps against the reference list
	task automatic compare_seq();
		if (obs_seq.size() != exp_seq.size()) begin
			errors++;
			$display("Request sequence has %0d steps where %0d were expected",
				obs_seq.size(), exp_seq.size());
		end else begin
			for (int i = 0; i < obs_seq.size(); i++) begin
				check_bit("read_req", obs_seq[i][3], exp_seq[i][3]);
				check_bit("write_req", obs_seq[i][2], exp_seq[i][2]);
				check_bit("z_cycle", obs_seq[i][1], exp_seq[i][1]);
				check_bit("dst_cycle", obs_seq[i][0], exp_seq[i][0]);
			end
		end
	endtask

	// Start one blit and watch it cycle by cycle until done
	task automatic run_blit(input blit_pkg::cmd_flags_t f, input blit_pkg::count_t cnt,
			input logic ack_rand, input logic gap_rand, input logic nw);
		logic first;
		logic ack_now;
		logic done_seen;
		logic done_due;
		logic [3:0] exp_strobe;
		int ack_wait;
		blit_pkg::count_t exp_left;
		first = 1'b1;
		done_seen = 1'b0;
		done_due = 1'b0;
		exp_left = cnt;
		ack_wait = 0;
		obs_seq.delete();
		pend_q.delete();
		expected_cycles(f, cnt, nw);
		while (!done_seen) begin
			@(negedge sys_clk);
			no_write = nw;
			inner_start = first;
			first = 1'b0;
			mem_ready = gap_rand ? (($unsigned($random(seed)) % 4) != 0) : 1'b1;
			// Acknowledge the oldest read once its delay has run out
			ack_now = 1'b0;
			if (pend_q.size() > 0) begin
				if (ack_wait == 0) begin
					ack_now = 1'b1;
					ack_wait = ack_rand ? int'($unsigned($random(seed)) % 4) : 0;
				end else begin
					ack_wait--;
				end
			end
			read_ack = ack_now;
			#2;
			exp_strobe = 4'b0000;
			if (ack_now)
				exp_strobe = strobe_for(pend_q.pop_front());
			check_bit("src_data_rd", src_data_rd, exp_strobe[3]);
			check_bit("src_z_rd", src_z_rd, exp_strobe[2]);
			check_bit("dst_data_rd", dst_data_rd, exp_strobe[1]);
			check_bit("dst_z_rd", dst_z_rd, exp_strobe[0]);
			// Back-pressure and no_write silence the requests
			if (!mem_ready) begin
				check_bit("read_req", read_req, 1'b0);
				check_bit("write_req", write_req, 1'b0);
			end
			if (nw)
				check_bit("write_req", write_req, 1'b0);
			if (write_req && pend_q.size() != 0) begin
				errors++;
				$display("Write request at %0t while a read is still unacknowledged", $time);
			end
			if (read_req)
				pend_q.push_back({z_cycle, dst_cycle});
			if (read_req || write_req) begin
				obs_seq.push_back({read_req, write_req, z_cycle, dst_cycle});
				check_bit("inner_busy", inner_busy, 1'b1);
			end
			// Done only in the cycle after the final write step
			if (!nw) begin
				check_count("pixels_left", pixels_left, exp_left);
				check_bit("inner_done", inner_done, done_due);
			end
			done_due = 1'b0;
			// Last write of a pixel takes the count down
			if (write_req && (z_cycle || !f.dstwrz_en)) begin
				done_due = (exp_left == blit_pkg::count_t'(1));
				exp_left = exp_left - blit_pkg::count_t'(1);
			end
			if (inner_done) begin
				done_seen = 1'b1;
				check_bit("inner_busy", inner_busy, 1'b0);
			end
		end
		// Done is a single pulse
		@(negedge sys_clk);
		read_ack = 1'b0;
		mem_ready = 1'b1;
		#2;
		check_bit("inner_done", inner_done, 1'b0);
		compare_seq();
	endtask

	`include "tb_blit_inner_tests.svh"

	initial begin
		#(watchdog_time);
		$display("Watchdog timeout, the test sequence did not complete in time");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		sys_clk = 1'b0;
		resetl = 1'b0;
		host_data = '0;
		cmd_load = 1'b0;
		count_load = 1'b0;
		inner_start = 1'b0;
		mem_ready = 1'b0;
		read_ack = 1'b0;
		no_write = 1'b0;
		repeat (10) @(negedge sys_clk);
		resetl = 1'b1;
		check_reset_state();
		test_full_sequence();
		test_all_flag_combos();
		test_ack_delays();
		test_ready_gaps();
		test_no_write();
		test_pixel_count();
		$display("Error count: %0d", errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+dv
source/blit_pkg.sv
source/blit_inner_seq.sv
source/blit_read_track.sv
source/blit_pixel_count.sv
source/blit_inner_top.sv
dv/tb_blit_inner.sv

/* Makefile */
TOP := tb_blit_inner

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@if ! grep -q "Finished with no errors" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
